// File: common/ttc_macros.svh
`ifndef TTC_MACROS_SVH
`define TTC_MACROS_SVH

// Datapath sizing
`define TTC_CNT_W        16
`define TTC_NUM_TIMERS   3

// Word address split, upper field picks the timer
`define TTC_ADDR_W       6
`define TTC_TMR_IDX_W    2
`define TTC_REG_OFS_W    4

// Register offsets inside one timer
`define TTC_OFS_CLK_CTRL   4'h0
`define TTC_OFS_CNTR_CTRL  4'h1
`define TTC_OFS_COUNT_VAL  4'h2 // Read only
`define TTC_OFS_INTERVAL   4'h3
`define TTC_OFS_MATCH_1    4'h4
`define TTC_OFS_MATCH_2    4'h5
`define TTC_OFS_MATCH_3    4'h6
`define TTC_OFS_INTR_STAT  4'h7 // Clear on read
`define TTC_OFS_INTR_EN    4'h8

`endif

// File: common/ttc_pkg.sv
package ttc_pkg;

  // --------------------------------------------------------------------------
  // Counter control register, bit 0 at the bottom
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic wave_pol;      // Bit 6, kept for read back only
    logic wave_en_n;     // Bit 5, kept for read back only
    logic restart;       // Bit 4, self clearing
    logic match_mode;    // Bit 3
    logic decrement;     // Bit 2, count down when set
    logic interval_mode; // Bit 1, interval when set, overflow when clear
    logic disable_n;     // Bit 0, counter stopped when set
  } cntr_ctrl_t;

  // Clock control register
  typedef struct packed {
    logic [3:0] prescale_val; // Bits 4:1, divide by 2**(val+1)
    logic       prescale_en;  // Bit 0
  } clk_ctrl_t;

  // Event bits, same layout for status and enable registers
  typedef struct packed {
    logic       overflow; // Bit 4
    logic [3:1] match;    // Bits 3:1
    logic       interval; // Bit 0
  } timer_events_t;

  // Per timer strobes out of the address decoder
  typedef struct packed {
    logic clk_ctrl;     // Write strobes
    logic cntr_ctrl;
    logic count_val_rd; // Read strobe, nothing to write here
    logic interval;
    logic match_1;
    logic match_2;
    logic match_3;
    logic intr_stat_rd; // Read strobe, doubles as status clear
    logic intr_en;
  } timer_sel_t;

endpackage

// File: ttc/ttc_reg_decode.sv
`timescale 1ns/1ns
`include "ttc_macros.svh"

module ttc_reg_decode (
  input  logic                      reg_wr,
  input  logic                      reg_rd,
  input  logic [`TTC_ADDR_W-1:0]    reg_addr,
  input  ttc_pkg::clk_ctrl_t        clk_ctrl_rd  [`TTC_NUM_TIMERS],
  input  ttc_pkg::cntr_ctrl_t       cntr_ctrl_rd [`TTC_NUM_TIMERS],
  input  logic [`TTC_CNT_W-1:0]     count_val_rd [`TTC_NUM_TIMERS],
  input  logic [`TTC_CNT_W-1:0]     interval_rd  [`TTC_NUM_TIMERS],
  input  logic [`TTC_CNT_W-1:0]     match_1_rd   [`TTC_NUM_TIMERS],
  input  logic [`TTC_CNT_W-1:0]     match_2_rd   [`TTC_NUM_TIMERS],
  input  logic [`TTC_CNT_W-1:0]     match_3_rd   [`TTC_NUM_TIMERS],
  input  ttc_pkg::timer_events_t    intr_stat_rd [`TTC_NUM_TIMERS],
  input  ttc_pkg::timer_events_t    intr_en_rd   [`TTC_NUM_TIMERS],
  output ttc_pkg::timer_sel_t       timer_sel    [`TTC_NUM_TIMERS],
  output logic [`TTC_CNT_W-1:0]     reg_rdata
);

  import ttc_pkg::*;

  logic [`TTC_TMR_IDX_W-1:0] tmr_idx; // Timer field, 3 is unmapped
  logic [`TTC_REG_OFS_W-1:0] reg_ofs; // Register field

  assign tmr_idx = reg_addr[`TTC_ADDR_W-1 -: `TTC_TMR_IDX_W];
  assign reg_ofs = reg_addr[`TTC_REG_OFS_W-1:0];

  // --------------------------------------------------------------------------
  // One hot strobes per timer
  // --------------------------------------------------------------------------
  for (genvar gt = 0; gt < `TTC_NUM_TIMERS; gt++)
  begin : g_sel
    timer_sel_t sel;

    always_comb
    begin
      sel = '0;
      if (tmr_idx == `TTC_TMR_IDX_W'(gt))
      begin
        case (reg_ofs)
          `TTC_OFS_CLK_CTRL:  sel.clk_ctrl     = reg_wr;
          `TTC_OFS_CNTR_CTRL: sel.cntr_ctrl    = reg_wr;
          `TTC_OFS_COUNT_VAL: sel.count_val_rd = reg_rd;
          `TTC_OFS_INTERVAL:  sel.interval     = reg_wr;
          `TTC_OFS_MATCH_1:   sel.match_1      = reg_wr;
          `TTC_OFS_MATCH_2:   sel.match_2      = reg_wr;
          `TTC_OFS_MATCH_3:   sel.match_3      = reg_wr;
          `TTC_OFS_INTR_STAT: sel.intr_stat_rd = reg_rd; // Status clear strobe
          `TTC_OFS_INTR_EN:   sel.intr_en      = reg_wr;
          default:            sel              = '0;
        endcase
      end
    end

    assign timer_sel[gt] = sel;
  end

  // --------------------------------------------------------------------------
  // Read data mux, zero extended, unmapped reads zero
  // --------------------------------------------------------------------------
  always_comb
  begin
    reg_rdata = '0;
    if (tmr_idx < `TTC_TMR_IDX_W'(`TTC_NUM_TIMERS))
    begin
      case (reg_ofs)
        `TTC_OFS_CLK_CTRL:  reg_rdata = `TTC_CNT_W'(clk_ctrl_rd[tmr_idx]);
        `TTC_OFS_CNTR_CTRL: reg_rdata = `TTC_CNT_W'(cntr_ctrl_rd[tmr_idx]);
        `TTC_OFS_COUNT_VAL: reg_rdata = count_val_rd[tmr_idx];
        `TTC_OFS_INTERVAL:  reg_rdata = interval_rd[tmr_idx];
        `TTC_OFS_MATCH_1:   reg_rdata = match_1_rd[tmr_idx];
        `TTC_OFS_MATCH_2:   reg_rdata = match_2_rd[tmr_idx];
        `TTC_OFS_MATCH_3:   reg_rdata = match_3_rd[tmr_idx];
        `TTC_OFS_INTR_STAT: reg_rdata = `TTC_CNT_W'(intr_stat_rd[tmr_idx]); // Old value
        `TTC_OFS_INTR_EN:   reg_rdata = `TTC_CNT_W'(intr_en_rd[tmr_idx]);
        default:            reg_rdata = '0;
      endcase
    end
  end

endmodule

// File: ttc/ttc_prescaler.sv
`timescale 1ns/1ns
`include "ttc_macros.svh"

module ttc_prescaler (
  input  logic                  pclk23,
  input  logic                  n_p_reset23,
  input  logic                  clk_ctrl_sel, // Write strobe for clock control
  input  logic [`TTC_CNT_W-1:0] wdata,
  output ttc_pkg::clk_ctrl_t    clk_ctrl,
  output logic                  count_en      // Count enable into the counter
);

  logic [`TTC_CNT_W-1:0] div_cnt;  // Free running divider
  logic [`TTC_CNT_W-1:0] div_mask; // Low bits up to the selected one
  logic                  div_hit;  // Masked bits all ones

  // --------------------------------------------------------------------------
  // Clock control register
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk23 or negedge n_p_reset23)
  begin
    if (!n_p_reset23)
      clk_ctrl <= '0;                            // Prescale off after reset
    else if (clk_ctrl_sel)
      clk_ctrl <= wdata[$bits(clk_ctrl)-1:0];
  end

  // --------------------------------------------------------------------------
  // Divider, restarted on every clock control write
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk23 or negedge n_p_reset23)
  begin
    if (!n_p_reset23)
      div_cnt <= '0;
    else if (clk_ctrl_sel)
      div_cnt <= '0;                             // First pulse a full period later
    else
      div_cnt <= div_cnt + 1'b1;                 // Wraps, period divides 2**16
  end

  // Val 0 keeps bit 0, val 15 keeps all 16 bits
  assign div_mask = ~({`TTC_CNT_W{1'b1}} << 1 << clk_ctrl.prescale_val);

  // Selected bit about to toggle from the all ones pattern
  assign div_hit = &(div_cnt | ~div_mask);

  // Strobe every cycle when the prescaler is off
  assign count_en = clk_ctrl.prescale_en ? div_hit : 1'b1;

endmodule

// File: ttc/ttc_counter_lite.sv
`timescale 1ns/1ns
`include "ttc_macros.svh"

module ttc_counter_lite (
  input  logic                   pclk23,
  input  logic                   n_p_reset23,
  input  logic [`TTC_CNT_W-1:0]  wdata,
  input  logic                   count_en,      // From the prescaler
  input  logic                   cntr_ctrl_sel,
  input  logic                   interval_sel,
  input  logic                   match_1_sel,
  input  logic                   match_2_sel,
  input  logic                   match_3_sel,
  output ttc_pkg::cntr_ctrl_t    cntr_ctrl,
  output logic [`TTC_CNT_W-1:0]  count_val,
  output logic [`TTC_CNT_W-1:0]  interval_val,
  output logic [`TTC_CNT_W-1:0]  match_1_val,
  output logic [`TTC_CNT_W-1:0]  match_2_val,
  output logic [`TTC_CNT_W-1:0]  match_3_val,
  output ttc_pkg::timer_events_t events         // Combinational event levels
);

  logic                  counting;     // Set after the first enabled step
  logic                  restart_pend; // Restart applied, bit clears next edge
  logic [`TTC_CNT_W-1:0] count_top;    // Wrap point, interval or full scale
  logic [`TTC_CNT_W-1:0] count_nxt;    // Next value when running
  logic                  ev_gate;      // Events qualified by run state
  logic                  count_zero;

  // --------------------------------------------------------------------------
  // Control, interval and match registers
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk23 or negedge n_p_reset23)
  begin
    if (!n_p_reset23)
    begin
      cntr_ctrl    <= '{disable_n: 1'b1, default: 1'b0}; // Reads back 01
      interval_val <= '0;
      match_1_val  <= '0;
      match_2_val  <= '0;
      match_3_val  <= '0;
    end
    else
    begin
      if (cntr_ctrl_sel)
        cntr_ctrl <= wdata[$bits(cntr_ctrl)-1:0];
      else if (restart_pend)
        cntr_ctrl.restart <= 1'b0;                   // Self clear

      if (interval_sel)
        interval_val <= wdata;
      if (match_1_sel)
        match_1_val <= wdata;
      if (match_2_sel)
        match_2_val <= wdata;
      if (match_3_sel)
        match_3_val <= wdata;
    end
  end

  // --------------------------------------------------------------------------
  // Next count for the four modes
  // --------------------------------------------------------------------------
  assign count_top  = cntr_ctrl.interval_mode ? interval_val : '1;
  assign count_zero = (count_val == '0);

  always_comb
  begin
    if (cntr_ctrl.decrement)
    begin
      // Down to 0, then reload interval or FFFF
      if (count_zero)
        count_nxt = count_top;
      else
        count_nxt = count_val - 1'b1;
    end
    else
    begin
      // Up to interval or FFFF, then back to 0
      if (count_val == count_top)
        count_nxt = '0;
      else
        count_nxt = count_val + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Counter state, moves only on count_en
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk23 or negedge n_p_reset23)
  begin
    if (!n_p_reset23)
    begin
      count_val    <= '0;
      counting     <= 1'b0;
      restart_pend <= 1'b0;
    end
    else if (count_en)
    begin
      if (cntr_ctrl.restart)
      begin
        // Up mode starts at 0, down mode at its top
        count_val    <= cntr_ctrl.decrement ? count_top : '0;
        counting     <= 1'b0;
        restart_pend <= 1'b1;
      end
      else
      begin
        if (!cntr_ctrl.disable_n)                    // Running
        begin
          count_val <= count_nxt;
          counting  <= 1'b1;
        end
        restart_pend <= 1'b0;                        // Count holds while disabled
      end
    end
  end

  // --------------------------------------------------------------------------
  // Event levels
  // --------------------------------------------------------------------------
  assign ev_gate = counting & ~cntr_ctrl.restart & ~cntr_ctrl.disable_n;

  assign events.interval = ev_gate & cntr_ctrl.interval_mode & count_zero;
  assign events.overflow = ev_gate & ~cntr_ctrl.interval_mode & count_zero;

  // Match compares only in match mode
  assign events.match[1] = ev_gate & cntr_ctrl.match_mode & (count_val == match_1_val);
  assign events.match[2] = ev_gate & cntr_ctrl.match_mode & (count_val == match_2_val);
  assign events.match[3] = ev_gate & cntr_ctrl.match_mode & (count_val == match_3_val);

endmodule

// File: ttc/ttc_intr_status.sv
`timescale 1ns/1ns
`include "ttc_macros.svh"

module ttc_intr_status (
  input  logic                   pclk23,
  input  logic                   n_p_reset23,
  input  logic [`TTC_CNT_W-1:0]  wdata,
  input  logic                   intr_en_sel,      // Enable mask write
  input  logic                   intr_stat_rd_sel, // Status read, clears it
  input  ttc_pkg::timer_events_t events,           // Levels from the counter
  output ttc_pkg::timer_events_t intr_stat,        // Sticky status
  output ttc_pkg::timer_events_t intr_en,          // Enable mask
  output logic                   irq               // Level, not registered
);

  logic [$bits(intr_stat)-1:0] stat_keep; // Status bits that survive this edge
  logic [$bits(intr_stat)-1:0] irq_vec;   // Enabled pending bits

  // --------------------------------------------------------------------------
  // Enable mask
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk23 or negedge n_p_reset23)
  begin
    if (!n_p_reset23)
      intr_en <= '0;                                 // All sources masked
    else if (intr_en_sel)
      intr_en <= wdata[$bits(intr_en)-1:0];
  end

  // --------------------------------------------------------------------------
  // Sticky status
  // --------------------------------------------------------------------------

  // A read drops everything held so far
  assign stat_keep = intr_stat_rd_sel ? '0 : intr_stat;

  always_ff @(posedge pclk23 or negedge n_p_reset23)
  begin
    if (!n_p_reset23)
      intr_stat <= '0;
    else
      intr_stat <= stat_keep | events;               // New event beats the clear
  end

  // Interrupt level from any enabled pending bit
  assign irq_vec = intr_stat & intr_en;
  assign irq     = |irq_vec;

endmodule

// File: ttc/ttc_lite.sv
`timescale 1ns/1ns
`include "ttc_macros.svh"

module ttc_lite (
  input  logic                        pclk23,
  input  logic                        n_p_reset23,
  input  logic                        reg_wr,     // Single cycle write strobe
  input  logic                        reg_rd,     // Single cycle read strobe
  input  logic [`TTC_ADDR_W-1:0]      reg_addr,   // Word address
  input  logic [`TTC_CNT_W-1:0]       reg_wdata,
  output logic [`TTC_CNT_W-1:0]       reg_rdata,  // Combinational from reg_addr
  output logic [`TTC_NUM_TIMERS:1]    irq         // One level per timer
);

  import ttc_pkg::*;

  // Read back values, one entry per timer
  clk_ctrl_t               clk_ctrl_rd  [`TTC_NUM_TIMERS];
  cntr_ctrl_t              cntr_ctrl_rd [`TTC_NUM_TIMERS];
  logic [`TTC_CNT_W-1:0]   count_val_rd [`TTC_NUM_TIMERS];
  logic [`TTC_CNT_W-1:0]   interval_rd  [`TTC_NUM_TIMERS];
  logic [`TTC_CNT_W-1:0]   match_1_rd   [`TTC_NUM_TIMERS];
  logic [`TTC_CNT_W-1:0]   match_2_rd   [`TTC_NUM_TIMERS];
  logic [`TTC_CNT_W-1:0]   match_3_rd   [`TTC_NUM_TIMERS];
  timer_events_t           intr_stat_rd [`TTC_NUM_TIMERS];
  timer_events_t           intr_en_rd   [`TTC_NUM_TIMERS];
  timer_sel_t              timer_sel    [`TTC_NUM_TIMERS]; // Decoded strobes

  // --------------------------------------------------------------------------
  // Bus decode and read mux
  // --------------------------------------------------------------------------
  ttc_reg_decode u_decode (
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .reg_addr     (reg_addr),
    .clk_ctrl_rd  (clk_ctrl_rd),
    .cntr_ctrl_rd (cntr_ctrl_rd),
    .count_val_rd (count_val_rd),
    .interval_rd  (interval_rd),
    .match_1_rd   (match_1_rd),
    .match_2_rd   (match_2_rd),
    .match_3_rd   (match_3_rd),
    .intr_stat_rd (intr_stat_rd),
    .intr_en_rd   (intr_en_rd),
    .timer_sel    (timer_sel),
    .reg_rdata    (reg_rdata)
  );

  // --------------------------------------------------------------------------
  // Timer slices
  // --------------------------------------------------------------------------
  for (genvar gi = 0; gi < `TTC_NUM_TIMERS; gi++)
  begin : g_timer
    logic          count_en; // Prescaler strobe
    timer_events_t events;   // Event levels into status

    ttc_prescaler u_prescaler (
      .pclk23       (pclk23),
      .n_p_reset23  (n_p_reset23),
      .clk_ctrl_sel (timer_sel[gi].clk_ctrl),
      .wdata        (reg_wdata),
      .clk_ctrl     (clk_ctrl_rd[gi]),
      .count_en     (count_en)
    );

    ttc_counter_lite u_counter (
      .pclk23        (pclk23),
      .n_p_reset23   (n_p_reset23),
      .wdata         (reg_wdata),
      .count_en      (count_en),
      .cntr_ctrl_sel (timer_sel[gi].cntr_ctrl),
      .interval_sel  (timer_sel[gi].interval),
      .match_1_sel   (timer_sel[gi].match_1),
      .match_2_sel   (timer_sel[gi].match_2),
      .match_3_sel   (timer_sel[gi].match_3),
      .cntr_ctrl     (cntr_ctrl_rd[gi]),
      .count_val     (count_val_rd[gi]),
      .interval_val  (interval_rd[gi]),
      .match_1_val   (match_1_rd[gi]),
      .match_2_val   (match_2_rd[gi]),
      .match_3_val   (match_3_rd[gi]),
      .events        (events)
    );

    ttc_intr_status u_intr (
      .pclk23           (pclk23),
      .n_p_reset23      (n_p_reset23),
      .wdata            (reg_wdata),
      .intr_en_sel      (timer_sel[gi].intr_en),
      .intr_stat_rd_sel (timer_sel[gi].intr_stat_rd),
      .events           (events),
      .intr_stat        (intr_stat_rd[gi]),
      .intr_en          (intr_en_rd[gi]),
      .irq              (irq[gi+1]) // Timers numbered from 1 on irq
    );
  end

endmodule

// File: verification/ttc_lite_tb.sv
`timescale 1ns/1ns
`include "ttc_macros.svh"

module ttc_lite_tb;

  localparam int MAX_REC = 128;  // Records the pattern memory can hold
  localparam int MARGIN  = 200;  // Extra cycles on top of the budget

  // Record opcodes
  localparam logic [3:0] OP_HEADER = 4'h0;
  localparam logic [3:0] OP_WRITE  = 4'h1;
  localparam logic [3:0] OP_READ   = 4'h2;
  localparam logic [3:0] OP_IDLE   = 4'h3;
  localparam logic [3:0] OP_IRQ    = 4'h4;
  localparam logic [3:0] OP_END    = 4'hf;

  logic                       pclk23;
  logic                       n_p_reset23;
  logic                       reg_wr;
  logic                       reg_rd;
  logic [`TTC_ADDR_W-1:0]     reg_addr;
  logic [`TTC_CNT_W-1:0]      reg_wdata;
  logic [`TTC_CNT_W-1:0]      reg_rdata;
  logic [`TTC_NUM_TIMERS:1]   irq;

  logic [15:0] pat_mem [0:4*MAX_REC-1]; // Four words per record

  int cycle_cnt;     // Watchdog
  int cycle_limit;
  int test_num;      // Current test, 0 before the first header
  int test_errs;
  int tests_run;
  int tests_failed;
  int errs_total;

  ttc_lite dut0 (
    .pclk23      (pclk23),
    .n_p_reset23 (n_p_reset23),
    .reg_wr      (reg_wr),
    .reg_rd      (reg_rd),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata),
    .irq         (irq)
  );

  always #10 pclk23 = ~pclk23; // 20 ns period

  // Run length guard
  always @(posedge pclk23)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
    begin
      $display("Timeout: the run went past %0d clock cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic string test_name(input int num);
    case (num)
      1: return "reset_values";
      2: return "overflow_count";
      3: return "interval_decrement";
      4: return "match_mode";
      5: return "prescale_by_4";
      6: return "restart";
      default: return "unnamed";
    endcase
  endfunction

  // Wrong value seen, one line per check
  task automatic note_mismatch(input string what, input logic [15:0] exp_val,
                               input logic [15:0] act_val);
    $display("FAILED %s: %s expected %04h actual %04h",
             test_name(test_num), what, exp_val, act_val);
    test_errs++;
    errs_total++;
  endtask

  task automatic write_reg(input logic [`TTC_ADDR_W-1:0] addr, input logic [15:0] data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge pclk23);           // Write lands here
    #2;
    reg_wr = 1'b0;
  endtask

  task automatic read_check(input logic [`TTC_ADDR_W-1:0] addr, input logic [15:0] exp_val);
    logic [15:0] act_val;
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge pclk23);           // Mid cycle, read data settled
    act_val = reg_rdata;
    if (act_val !== exp_val)
      note_mismatch($sformatf("read of address %02h", addr), exp_val, act_val);
    @(posedge pclk23);           // Clear on read happens on this edge
    #2;
    reg_rd = 1'b0;
  endtask

  task automatic idle_cycles(input int num);
    repeat (num) @(posedge pclk23);
    #2;
  endtask

  task automatic check_irq(input logic [15:0] exp_val);
    logic [15:0] act_val;
    act_val = {{(`TTC_CNT_W-`TTC_NUM_TIMERS){1'b0}}, irq};
    if (act_val !== exp_val)
      note_mismatch("irq", exp_val, act_val);
  endtask

  // One line per finished test
  task automatic close_test();
    if (test_num > 0)
    begin
      tests_run++;
      if (test_errs == 0)
        $display("test %0d %s: passed", test_num, test_name(test_num));
      else
      begin
        tests_failed++;
        $display("test %0d %s: %0d wrong check(s)", test_num, test_name(test_num), test_errs);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Pattern replay
  // --------------------------------------------------------------------------
  initial
  begin : replay
    int          n_rec;
    int          idle_sum;
    logic        end_found;
    logic [3:0]  op;
    logic [15:0] addr;
    logic [15:0] data;
    logic [15:0] exp_val;
    pclk23       = 1'b0;
    n_p_reset23  = 1'b0;
    reg_wr       = 1'b0;
    reg_rd       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    cycle_cnt    = 0;
    cycle_limit  = MARGIN;
    test_num     = 0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    errs_total   = 0;
    $readmemh("verification/ttc_lite_patterns.txt", pat_mem);

    // Budget from the idle counts and the record count
    n_rec     = 0;
    idle_sum  = 0;
    end_found = 1'b0;
    while (n_rec < MAX_REC && !end_found)
    begin
      if (pat_mem[4*n_rec][3:0] === OP_END)
        end_found = 1'b1;
      else
      begin
        if (pat_mem[4*n_rec][3:0] === OP_IDLE)
          idle_sum += int'(pat_mem[4*n_rec+2]);
        n_rec++;
      end
    end
    cycle_limit = idle_sum + n_rec + MARGIN;

    repeat (4) @(posedge pclk23); // Reset held 4 cycles
    #2;
    n_p_reset23 = 1'b1;

    if (!end_found)
    begin
      $display("The pattern file has no end record");
      errs_total++;
    end

    for (int r = 0; r < n_rec; r++)
    begin
      op      = pat_mem[4*r][3:0];
      addr    = pat_mem[4*r+1];
      data    = pat_mem[4*r+2];
      exp_val = pat_mem[4*r+3];
      case (op)
        OP_HEADER:
        begin
          close_test();
          test_num  = int'(data);
          test_errs = 0;
        end
        OP_WRITE: write_reg(addr[`TTC_ADDR_W-1:0], data);
        OP_READ:  read_check(addr[`TTC_ADDR_W-1:0], exp_val);
        OP_IDLE:  idle_cycles(int'(data));
        OP_IRQ:   check_irq(exp_val);
        default:
        begin
          $display("Pattern record %0d has an unknown opcode %0h", r, op);
          test_errs++;
          errs_total++;
        end
      endcase
    end
    close_test();

    $display("tests run %0d, passed %0d, failed %0d, wrong checks %0d",
             tests_run, tests_run - tests_failed, tests_failed, errs_total);
    if (errs_total == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: ttc_lite.f
+incdir+common
common/ttc_pkg.sv
ttc/ttc_reg_decode.sv
ttc/ttc_prescaler.sv
ttc/ttc_counter_lite.sv
ttc/ttc_intr_status.sv
ttc/ttc_lite.sv
verification/ttc_lite_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ttc_lite testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f ttc_lite.f --top-module ttc_lite_tb \
  -Mdir obj_dir -o ttc_lite_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ttc_lite_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The log decides pass or fail
if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0

// File: verification/ttc_lite_patterns.txt
// Columns: opcode address data expected, all hex
// Opcode 0 test header (data = test number), 1 write, 2 read and compare, 3 idle data cycles, 4 irq check, F end
0 00 0001 0000 // Reset values
2 00 0000 0000
2 01 0000 0001
2 02 0000 0000
2 03 0000 0000
2 07 0000 0000
2 08 0000 0000
2 21 0000 0001
2 31 0000 0000
4 00 0000 0000
0 00 0002 0000 // Overflow mode, timer 0
1 01 0000 0000
3 00 000A 0000
2 02 0000 000A
2 02 0000 000B
1 01 0014 0000
3 00 000A 0000
2 02 0000 FFF7
2 01 0000 0004
1 01 0001 0000
0 00 0003 0000 // Interval decrement, timer 1
1 13 0004 0000
1 11 0006 0000
3 00 0008 0000
4 00 0000 0000
1 18 0001 0000
4 00 0000 0002
2 17 0000 0001
2 17 0000 0000
4 00 0000 0002
1 11 0001 0000
1 18 0000 0000
4 00 0000 0000
0 00 0004 0000 // Match mode, timer 2
1 24 0003 0000
1 25 0006 0000
1 26 0009 0000
1 28 0004 0000
1 21 0008 0000
3 00 0005 0000
4 00 0000 0000
3 00 0005 0000
4 00 0000 0004
2 27 0000 000E
4 00 0000 0000
1 21 0001 0000
0 00 0005 0000 // Prescale by 4, timer 0
1 00 0003 0000
1 01 0010 0000
3 00 0028 0000
2 02 0000 0009
2 00 0000 0003
0 00 0006 0000 // Restart, timer 0
2 02 0000 0009
1 00 0000 0000
1 01 0010 0000
3 00 0001 0000
2 02 0000 0000
2 01 0000 0000
2 02 0000 0001
F 00 0000 0000
